// ==== src/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// direct mapped, one line per set.
`define ICACHE_SETS 16

// 32-bit words per line.
`define ICACHE_LINE_WORDS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// request credits the memory grants out of reset.
`define ICACHE_MEM_CREDITS 2

`endif

// ==== src/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

    // instruction word or byte address.
    typedef logic [31:0] word_t;

    // address fields.
    typedef logic [23:0] tag_t;
    typedef logic [3:0]  index_t;
    typedef logic [1:0]  offset_t;

    // fetch address split into its cache fields.
    typedef struct packed {
        tag_t        tag;
        index_t      index;
        offset_t     offset;
        logic [1:0]  byte_sel;
    } addr_t;

    // one cache line, word 0 in the low bits.
    typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

endpackage

// ==== src/icache_sram.sv ====
module icache_sram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 16
) (
    input  logic                clk_i,
    input  logic                en_i,
    input  logic                we_i,
    input  icache_pkg::index_t  index_i,
    input  entry_t              wdata_i,
    output entry_t              rdata_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    entry_t mem_q [depth];

    // write port.
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            mem_q[index_i] <= wdata_i;
        end
    end

    // registered read port returns the old data on a write to the same entry.
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem_q[index_i];
        end
    end

endmodule

// ==== src/icache_refill_port.sv ====
`include "icache_defines.svh"

module icache_refill_port (
    input  logic               clk_i,
    input  logic               rst_i,

    // from the cache controller.
    input  logic               refill_req_i,
    input  icache_pkg::word_t  refill_addr_i,
    output logic               refill_busy_o,

    // to the memory controller.
    output logic               mem_req_valid_o,
    output icache_pkg::word_t  mem_req_addr_o,
    input  logic               mem_credit_i
);

    import icache_pkg::*;

    localparam int unsigned max_credits = `ICACHE_MEM_CREDITS;
    localparam int unsigned credit_w    = $clog2(max_credits + 1);

    logic                pending_q;
    word_t               addr_q;
    logic [credit_w-1:0] credit_cnt_q;
    logic                issue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request hold and issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a held request goes out as soon as one credit is left.
    assign issue = pending_q && (credit_cnt_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pending_q <= 1'b0;
        end else if (refill_req_i) begin
            pending_q <= 1'b1;
        end else if (issue) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_req_i) begin
            addr_q <= refill_addr_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credit counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            credit_cnt_q <= credit_w'(max_credits);
        end else begin
            case ({issue, mem_credit_i})
                2'b10: credit_cnt_q <= credit_cnt_q - 1'b1;
                2'b01: begin
                    // saturate at the granted pool size.
                    if (credit_cnt_q != credit_w'(max_credits)) begin
                        credit_cnt_q <= credit_cnt_q + 1'b1;
                    end
                end
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    assign refill_busy_o   = pending_q;
    assign mem_req_valid_o = issue;
    assign mem_req_addr_o  = addr_q;

endmodule

// ==== src/icache_ctrl.sv ====
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,

    // fetch side.
    input  logic                fetch_valid_i,
    input  icache_pkg::word_t   fetch_addr_i,
    input  logic                flush_i,
    output logic                fetch_done_o,
    output icache_pkg::word_t   fetch_instr_o,

    // tag array.
    output logic                tag_en_o,
    output logic                tag_we_o,
    output icache_pkg::tag_t    tag_wdata_o,
    input  icache_pkg::tag_t    tag_rdata_i,

    // line array.
    output logic                line_en_o,
    output logic                line_we_o,
    output icache_pkg::line_t   line_wdata_o,
    input  icache_pkg::line_t   line_rdata_i,

    // shared array index.
    output icache_pkg::index_t  index_o,

    // refill port.
    output logic                refill_req_o,
    output icache_pkg::word_t   refill_addr_o,
    input  logic                refill_busy_i,

    // memory response.
    input  logic                mem_resp_valid_i,
    input  icache_pkg::line_t   mem_resp_line_i
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_fill
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    addr_t                   fetch_f;
    addr_t                   req_q;
    line_t                   fill_line_q;
    logic [`ICACHE_SETS-1:0] valid_q;
    logic                    fetch_done_q;
    word_t                   fetch_instr_q;
    logic                    start;
    logic                    hit;
    logic                    resp_take;
    logic                    array_en;
    logic                    array_we;

    assign fetch_f = addr_t'(fetch_addr_i);

    // a new lookup waits out the cycle in which the last one is answered.
    assign start = (state_q == st_idle) && fetch_valid_i && !fetch_done_q;

    assign hit = valid_q[req_q.index] && (tag_rdata_i == req_q.tag);

    // only one miss is ever open, so the next response is ours.
    assign resp_take = (state_q == st_refill) && mem_resp_valid_i && !refill_busy_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                state_d = hit ? st_idle : st_refill;
            end
            st_refill: begin
                if (resp_take) begin
                    state_d = st_fill;
                end
            end
            st_fill: begin
                state_d = st_idle;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            req_q <= fetch_f;
        end
        if (resp_take) begin
            fill_line_q <= mem_resp_line_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // valid bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
        end else if (flush_i && (state_q == st_idle)) begin
            valid_q <= '0;
        end else if (state_q == st_fill) begin
            valid_q[req_q.index] <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            fetch_done_q <= 1'b0;
        end else begin
            fetch_done_q <= ((state_q == st_lookup) && hit) || resp_take;
        end
    end

    // word comes from the array on a hit, from the response on a refill.
    always_ff @(posedge clk_i) begin
        if ((state_q == st_lookup) && hit) begin
            fetch_instr_q <= line_rdata_i[req_q.offset];
        end else if (resp_take) begin
            fetch_instr_q <= mem_resp_line_i[req_q.offset];
        end
    end

    assign fetch_done_o  = fetch_done_q;
    assign fetch_instr_o = fetch_instr_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // array and refill control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign array_en = start || (state_q == st_fill);
    assign array_we = (state_q == st_fill);

    assign tag_en_o     = array_en;
    assign tag_we_o     = array_we;
    assign tag_wdata_o  = req_q.tag;
    assign line_en_o    = array_en;
    assign line_we_o    = array_we;
    assign line_wdata_o = fill_line_q;

    // read with the incoming address, write with the held one.
    assign index_o = (state_q == st_idle) ? fetch_f.index : req_q.index;

    assign refill_req_o  = (state_q == st_lookup) && !hit;
    assign refill_addr_o = {req_q.tag, req_q.index, {$bits(offset_t) + 2{1'b0}}};

endmodule

// ==== src/icache_top.sv ====
`include "icache_defines.svh"

module icache_top (
    input  logic               clk_i,
    input  logic               rst_i,

    // fetch side.
    input  logic               fetch_valid_i,
    input  icache_pkg::word_t  fetch_addr_i,
    input  logic               flush_i,
    output logic               fetch_done_o,
    output icache_pkg::word_t  fetch_instr_o,

    // memory side.
    output logic               mem_req_valid_o,
    output icache_pkg::word_t  mem_req_addr_o,
    input  logic               mem_credit_i,
    input  logic               mem_resp_valid_i,
    input  icache_pkg::line_t  mem_resp_line_i
);

    import icache_pkg::*;

    logic    tag_en;
    logic    tag_we;
    tag_t    tag_wdata;
    tag_t    tag_rdata;
    logic    line_en;
    logic    line_we;
    line_t   line_wdata;
    line_t   line_rdata;
    index_t  index;
    logic    refill_req;
    word_t   refill_addr;
    logic    refill_busy;

    icache_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_addr_i     (fetch_addr_i),
        .flush_i          (flush_i),
        .fetch_done_o     (fetch_done_o),
        .fetch_instr_o    (fetch_instr_o),
        .tag_en_o         (tag_en),
        .tag_we_o         (tag_we),
        .tag_wdata_o      (tag_wdata),
        .tag_rdata_i      (tag_rdata),
        .line_en_o        (line_en),
        .line_we_o        (line_we),
        .line_wdata_o     (line_wdata),
        .line_rdata_i     (line_rdata),
        .index_o          (index),
        .refill_req_o     (refill_req),
        .refill_addr_o    (refill_addr),
        .refill_busy_i    (refill_busy),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_line_i  (mem_resp_line_i)
    );

    // tags and lines share one index.
    icache_sram #(.entry_t(tag_t), .depth(`ICACHE_SETS)) tag_ram (
        .clk_i   (clk_i),
        .en_i    (tag_en),
        .we_i    (tag_we),
        .index_i (index),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

    icache_sram #(.entry_t(line_t), .depth(`ICACHE_SETS)) line_ram (
        .clk_i   (clk_i),
        .en_i    (line_en),
        .we_i    (line_we),
        .index_i (index),
        .wdata_i (line_wdata),
        .rdata_o (line_rdata)
    );

    icache_refill_port u_refill_port (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .refill_req_i    (refill_req),
        .refill_addr_i   (refill_addr),
        .refill_busy_o   (refill_busy),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_credit_i    (mem_credit_i)
    );

endmodule

// ==== bench/icache_properties.sv ====
`include "icache_defines.svh"

module icache_properties #(
    parameter int credit_w = $clog2(`ICACHE_MEM_CREDITS + 1)
) (
    input logic                clk_i,
    input logic                rst_i,
    input logic                req_valid_i,
    input logic                credit_i,
    input logic [credit_w-1:0] credit_cnt_i
);

    int unsigned fail_cnt = 0;
    int          free_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credit pool
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // free credits as seen on the memory pins alone.
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            free_q <= `ICACHE_MEM_CREDITS;
        end else begin
            free_q <= free_q - int'(req_valid_i) + int'(credit_i);
        end
    end

    issue_needs_credit: assert property (
        @(posedge clk_i) disable iff (!rst_i) req_valid_i |-> free_q > 0
    ) else begin
        $error("request issued with an empty credit pool");
        fail_cnt++;
    end

    credit_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_i) credit_cnt_i <= `ICACHE_MEM_CREDITS
    ) else begin
        $error("credit count above the granted pool");
        fail_cnt++;
    end

    // the counter follows the requests and returns on the pins.
    credit_matches_pins: assert property (
        @(posedge clk_i) disable iff (!rst_i) credit_cnt_i == free_q
    ) else begin
        $error("credit count disagrees with the memory pins");
        fail_cnt++;
    end

endmodule

bind icache_refill_port icache_properties u_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (mem_req_valid_o),
    .credit_i     (mem_credit_i),
    .credit_cnt_i (credit_cnt_q)
);

// ==== bench/icache_tb.sv ====
`include "icache_defines.svh"

module icache_tb;

    import icache_pkg::*;

    localparam int    period      = 40;
    localparam int    skew        = 2;
    localparam int    fetch_count = 20;
    localparam int    fetch_limit = 40;
    localparam int    max_cycles  = 5 + fetch_count * (fetch_limit + 1) + 1;
    localparam word_t pattern     = 32'h5a5a_0f0f;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    word_t       fetch_addr;
    logic        flush;
    logic        fetch_done;
    word_t       fetch_instr;
    logic        mem_req_valid;
    word_t       mem_req_addr;
    logic        mem_credit;
    logic        mem_resp_valid;
    line_t       mem_resp_line;
    integer      seed = 32'hd8e6_bb49;
    int unsigned credit_extra = 0;
    int unsigned outstanding = 0;
    int unsigned peak = 0;
    word_t       req_log[$];

    icache_top DUT (
        .clk_i            (clk),
        .rst_i            (rst),
        .fetch_valid_i    (fetch_valid),
        .fetch_addr_i     (fetch_addr),
        .flush_i          (flush),
        .fetch_done_o     (fetch_done),
        .fetch_instr_o    (fetch_instr),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_addr_o   (mem_req_addr),
        .mem_credit_i     (mem_credit),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_line_i  (mem_resp_line)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // every memory word holds its own byte address xor the pattern.
    function automatic word_t mem_word(input word_t addr);
        return {addr[31:2], 2'b00} ^ pattern;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model and run limit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : memory_model
        int unsigned now;
        int unsigned due;
        int unsigned last_due;
        word_t       addr;
        word_t       resp_addr[$];
        int unsigned resp_due[$];
        int unsigned credit_due[$];
        now = 0;
        last_due = 0;
        mem_credit = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_line = '0;
        forever begin
            @(posedge clk);
            now++;
            if (rst && mem_req_valid) begin
                req_log.push_back(mem_req_addr);
                resp_addr.push_back(mem_req_addr);
                resp_due.push_back(now + 3);
                // credits go back in request order.
                due = now + 1 + ($unsigned($random(seed)) % 6) + credit_extra;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                credit_due.push_back(due);
                outstanding++;
                if (outstanding > peak) begin
                    peak = outstanding;
                end
                if (outstanding > `ICACHE_MEM_CREDITS) begin
                    abort_run("memory received a request while no credit was free");
                end
            end
            #skew;
            mem_credit = 1'b0;
            mem_resp_valid = 1'b0;
            if (resp_due.size() > 0 && resp_due[0] <= now) begin
                addr = resp_addr.pop_front();
                void'(resp_due.pop_front());
                for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
                    mem_resp_line[w] = mem_word({addr[31:4], 4'h0} + 4 * w);
                end
                mem_resp_valid = 1'b1;
            end
            if (credit_due.size() > 0 && credit_due[0] <= now) begin
                void'(credit_due.pop_front());
                mem_credit = 1'b1;
                outstanding--;
            end
        end
    end

    initial begin : watchdog
        int unsigned cycle_cnt;
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (DUT.u_refill_port.u_props.fail_cnt != 0) begin
                abort_run("a refill port assertion failed");
            end
            if (cycle_cnt > max_cycles) begin
                abort_run($sformatf("run did not finish within %0d cycles", max_cycles));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch tasks and directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one handshake followed by an idle cycle.
    task automatic fetch(input word_t addr, output word_t instr, output int unsigned latency);
        fetch_valid = 1'b1;
        fetch_addr = addr;
        latency = 0;
        do begin
            @(posedge clk);
            #skew;
            latency++;
            if (latency > fetch_limit) begin
                abort_run($sformatf("fetch of address %h never completed", addr));
            end
        end while (!fetch_done);
        instr = fetch_instr;
        fetch_valid = 1'b0;
        @(posedge clk);
        #skew;
    endtask

    task automatic fetch_check(input word_t addr, input bit miss);
        word_t       instr;
        int unsigned latency;
        int unsigned reqs;
        reqs = req_log.size();
        fetch(addr, instr, latency);
        check_value("fetch_instr_o", instr, mem_word(addr));
        check_value("memory request count", req_log.size() - reqs, miss);
        if (miss) begin
            check_value("mem_req_addr_o", req_log[$], {addr[31:4], 4'h0});
        end else begin
            check_value("hit latency", latency, 2);
        end
    endtask

    task automatic cold_miss();
        fetch_check(32'h0000_1234, 1'b1);
    endtask

    task automatic repeat_hit();
        fetch_check(32'h0000_1234, 1'b0);
    endtask

    task automatic line_hits();
        fetch_check(32'h0004_5678, 1'b1);
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            fetch_check(32'h0004_5670 + 4 * w, 1'b0);
        end
    endtask

    // both addresses map to index 8 with different tags.
    task automatic eviction();
        for (int i = 0; i < 4; i++) begin
            fetch_check(i[0] ? 32'h0002_0084 : 32'h0001_0088, 1'b1);
        end
    endtask

    task automatic flush_invalidate();
        fetch_check(32'h0000_0300, 1'b1);
        fetch_check(32'h0000_0300, 1'b0);
        flush = 1'b1;
        @(posedge clk);
        #skew;
        flush = 1'b0;
        fetch_check(32'h0000_0300, 1'b1);
    endtask

    task automatic slow_credit();
        credit_extra = 12;
        peak = outstanding;
        for (int i = 0; i < 6; i++) begin
            fetch_check(32'h0010_0000 + i * 32'h0000_1010, 1'b1);
        end
        check_value("peak uncredited requests", peak, `ICACHE_MEM_CREDITS);
    endtask

    initial begin : run_tests
        rst = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        flush = 1'b0;
        repeat (5) @(posedge clk);
        #skew;
        rst = 1'b1;
        check_value("fetch_done_o", fetch_done, 0);
        check_value("mem_req_valid_o", mem_req_valid, 0);
        cold_miss();
        repeat_hit();
        line_hits();
        eviction();
        flush_invalidate();
        slow_credit();
        if (DUT.u_refill_port.u_props.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("%0d refill port assertions failed", DUT.u_refill_port.u_props.fail_cnt);
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== icache_top.f ====
+incdir+src
src/icache_pkg.sv
src/icache_sram.sv
src/icache_refill_port.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/icache_properties.sv
bench/icache_tb.sv

// ==== Makefile ====
TOP := icache_tb
BIN := obj_dir/V$(TOP)
SRC := $(filter-out +%,$(shell cat icache_top.f)) src/icache_defines.svh

.PHONY: all run clean

all: run

$(BIN): icache_top.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f icache_top.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
